// File: Bender.yml
package:
  name: router_stat_regs

sources:
  - files:
      - logic/router_regs_pkg.sv
      - logic/port_counter_bank.sv
      - logic/apb_register_file.sv
      - logic/router_stat_regs.sv
  - target: test
    files:
      - verification/router_stat_checker.sv
      - verification/router_stat_regs_tb.sv

// File: logic/apb_register_file.sv
`timescale 1ns/1ps
`default_nettype none

// APB register file of the router status block
// Address decode, control and status registers, read data from both banks

module apb_register_file #(
    parameter int NUM_ING_PORTS = 4,
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic                               core_clk_ifc,
    input  logic                               peripheral_sresetn_core,
    input  router_regs_pkg::apb_req_t          apb_req,
    input  logic [router_regs_pkg::CNTR_W-1:0] ing_read_data,
    input  logic [router_regs_pkg::CNTR_W-1:0] egr_read_data,
    output router_regs_pkg::apb_rsp_t          apb_rsp,
    output logic [NUM_ING_PORTS-1:0]           ing_port_enable,
    output logic [NUM_EGR_PORTS-1:0]           egr_port_enable,
    output logic [NUM_ING_PORTS-1:0]           ing_sample_req,
    output logic [NUM_EGR_PORTS-1:0]           egr_sample_req,
    output router_regs_pkg::cntr_sel_t         ing_read_sel,
    output router_regs_pkg::cntr_sel_t         egr_read_sel
);

    import router_regs_pkg::*;

    localparam logic [DATA_W-1:0] VERSION_WORD = {MODULE_VERSION, MODULE_ID};
    // Egress count in 15:8, ingress count in 7:0
    localparam logic [DATA_W-1:0] PARAMS_WORD  = {16'h0000, 8'(NUM_EGR_PORTS),
                                                  8'(NUM_ING_PORTS)};

    logic [ADDR_W-3:0]        word_addr;
    reg_addr_e                reg_sel;
    logic                     in_range;
    logic                     writable;
    logic                     access;
    logic                     bus_err;
    logic                     wr_en;
    logic [NUM_ING_PORTS-1:0] ing_enable_stat;
    logic [NUM_EGR_PORTS-1:0] egr_enable_stat;
    logic [DATA_W-1:0]        rd_word;

    ////////////////////////////////////////////////////////////////////////////
    // Decode

    assign word_addr = apb_req.paddr[ADDR_W-1:2];
    assign reg_sel   = reg_addr_e'(word_addr);
    assign in_range  = (word_addr < TOTAL_REGS);
    assign access    = apb_req.psel && apb_req.penable;

    always_comb begin
        case (reg_sel)
            ING_PORT_ENABLE_CON,
            EGR_PORT_ENABLE_CON,
            ING_CNTRS_SAMPLE_CON,
            ING_CNTRS_READ_SEL,
            EGR_CNTRS_SAMPLE_CON,
            EGR_CNTRS_READ_SEL: writable = 1'b1;
            default:            writable = 1'b0;
        endcase
    end

    // Unmapped address, or a write to a read-only register
    assign bus_err = !in_range || (apb_req.pwrite && !writable);
    assign wr_en   = access && apb_req.pwrite && !bus_err;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_port_enable <= '1;
            egr_port_enable <= '1;
            ing_sample_req  <= '0;
            egr_sample_req  <= '0;
            ing_read_sel    <= '0;
            egr_read_sel    <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                ING_PORT_ENABLE_CON:  ing_port_enable <= apb_req.pwdata[NUM_ING_PORTS-1:0];
                EGR_PORT_ENABLE_CON:  egr_port_enable <= apb_req.pwdata[NUM_EGR_PORTS-1:0];
                ING_CNTRS_SAMPLE_CON: ing_sample_req  <= apb_req.pwdata[NUM_ING_PORTS-1:0];
                EGR_CNTRS_SAMPLE_CON: egr_sample_req  <= apb_req.pwdata[NUM_EGR_PORTS-1:0];
                ING_CNTRS_READ_SEL:   ing_read_sel    <= apb_req.pwdata[$bits(cntr_sel_t)-1:0];
                EGR_CNTRS_READ_SEL:   egr_read_sel    <= apb_req.pwdata[$bits(cntr_sel_t)-1:0];
                default: ;
            endcase
        end
    end

    // Status mirrors trail the enables by one cycle
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_enable_stat <= '1;
            egr_enable_stat <= '1;
        end else begin
            ing_enable_stat <= ing_port_enable;
            egr_enable_stat <= egr_port_enable;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data

    always_comb begin
        case (reg_sel)
            VERSION_ID:           rd_word = VERSION_WORD;
            PARAMS:               rd_word = PARAMS_WORD;
            ING_PORT_ENABLE_CON:  rd_word = DATA_W'(ing_port_enable);
            EGR_PORT_ENABLE_CON:  rd_word = DATA_W'(egr_port_enable);
            ING_PORT_ENABLE_STAT: rd_word = DATA_W'(ing_enable_stat);
            EGR_PORT_ENABLE_STAT: rd_word = DATA_W'(egr_enable_stat);
            ING_CNTRS_SAMPLE_CON: rd_word = DATA_W'(ing_sample_req);
            ING_CNTRS_READ_SEL:   rd_word = DATA_W'(ing_read_sel);
            ING_CNTRS_READ_DATA:  rd_word = DATA_W'(ing_read_data);
            EGR_CNTRS_SAMPLE_CON: rd_word = DATA_W'(egr_sample_req);
            EGR_CNTRS_READ_SEL:   rd_word = DATA_W'(egr_read_sel);
            EGR_CNTRS_READ_DATA:  rd_word = DATA_W'(egr_read_data);
            default:              rd_word = '0;
        endcase
    end

    // No wait states, response valid in the access cycle
    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && bus_err;
        if (access && !apb_req.pwrite && !bus_err) begin
            apb_rsp.prdata = rd_word;
        end
    end

    assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

// File: logic/port_counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

// Counter bank for one traffic direction
// Counts event strobe edges per port and captures snapshots on sample edges

module port_counter_bank #(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_EVENTS = 1
) (
    input  logic                                           core_clk_ifc,
    input  logic                                           peripheral_sresetn_core,
    input  router_regs_pkg::port_traffic_t [NUM_PORTS-1:0] traffic,
    input  logic [NUM_PORTS-1:0][NUM_EVENTS-1:0]           events,
    input  logic [NUM_PORTS-1:0]                           sample_req,
    input  router_regs_pkg::cntr_sel_t                     read_sel,
    output logic [router_regs_pkg::CNTR_W-1:0]             read_data
);

    import router_regs_pkg::*;

    // Traffic words first, then the locally kept event counts
    localparam int NUM_WORDS = NUM_TRAFFIC_CNTRS + NUM_EVENTS;

    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0]             events_d;
    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0]             event_edge;
    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0][CNTR_W-1:0] event_cnt;
    logic [NUM_PORTS-1:0]                             sample_d;
    logic [NUM_PORTS-1:0]                             sample_rise;
    logic [NUM_PORTS-1:0][NUM_WORDS-1:0][CNTR_W-1:0]  snapshot;
    logic                                             sel_valid;
    logic [CNTR_W-1:0]                                sel_word;

    ////////////////////////////////////////////////////////////////////////////
    // Edge detection

    assign event_edge  = events & ~events_d;
    assign sample_rise = sample_req & ~sample_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            events_d <= '0;
            sample_d <= '0;
        end else begin
            events_d <= events;
            sample_d <= sample_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Event counters and snapshots

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            event_cnt <= '0;
            snapshot  <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (sample_rise[p]) begin
                    snapshot[p][PKT_CNT]  <= traffic[p].pkt_cnt;
                    snapshot[p][BYTE_CNT] <= traffic[p].byte_cnt;
                    snapshot[p][ERR_CNT]  <= traffic[p].err_cnt;
                end
                for (int e = 0; e < NUM_EVENTS; e++) begin
                    if (sample_rise[p]) begin
                        snapshot[p][int'(EVENT0) + e] <= event_cnt[p][e];
                        // Count restarts, keeping an edge that lands on the sample
                        event_cnt[p][e] <= CNTR_W'(event_edge[p][e]);
                    end else if (event_edge[p][e]) begin
                        event_cnt[p][e] <= event_cnt[p][e] + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read select

    assign sel_valid = (int'(read_sel.port) < NUM_PORTS) &&
                       (int'(read_sel.index) < NUM_WORDS);

    always_comb begin
        sel_word = '0;
        if (sel_valid) begin
            sel_word = snapshot[read_sel.port][read_sel.index];
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            read_data <= '0;
        end else begin
            read_data <= sel_word;
        end
    end

    // Out of range selection reads as zero
    assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        !sel_valid |=> (read_data == '0));

    // Snapshot of a port holds unless its sample bit rose
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_snapshot_check
        assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
            !sample_rise[p] |=> $stable(snapshot[p]));
    end

endmodule

`default_nettype wire

// File: logic/router_regs_pkg.sv
`default_nettype none

// Shared widths, register map and bus types of the router status registers
// APB request and response groups, traffic counts and counter selection

package router_regs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and identification

    localparam int DATA_W            = 32;
    localparam int ADDR_W            = 8;
    localparam int CNTR_W            = 32;
    localparam int NUM_TRAFFIC_CNTRS = 3;

    localparam logic [15:0] MODULE_ID      = 16'h0052;
    localparam logic [15:0] MODULE_VERSION = 16'h0100;

    ////////////////////////////////////////////////////////////////////////////
    // Register map, in word addresses

    typedef enum logic [ADDR_W-3:0] {
        VERSION_ID,
        PARAMS,
        ING_PORT_ENABLE_CON,
        EGR_PORT_ENABLE_CON,
        ING_PORT_ENABLE_STAT,
        EGR_PORT_ENABLE_STAT,
        ING_CNTRS_SAMPLE_CON,
        ING_CNTRS_READ_SEL,
        ING_CNTRS_READ_DATA,
        EGR_CNTRS_SAMPLE_CON,
        EGR_CNTRS_READ_SEL,
        EGR_CNTRS_READ_DATA,
        TOTAL_REGS
    } reg_addr_e;

    // Word index within one port snapshot
    typedef enum logic [7:0] {
        PKT_CNT,
        BYTE_CNT,
        ERR_CNT,
        EVENT0,
        EVENT1
    } cntr_index_e;

    ////////////////////////////////////////////////////////////////////////////
    // Packed groups

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [CNTR_W-1:0] pkt_cnt;
        logic [CNTR_W-1:0] byte_cnt;
        logic [CNTR_W-1:0] err_cnt;
    } port_traffic_t;

    // Port in bits 15:8, counter index in bits 7:0
    typedef struct packed {
        logic [7:0] port;
        logic [7:0] index;
    } cntr_sel_t;

endpackage

`default_nettype wire

// File: logic/router_stat_regs.sv
`timescale 1ns/1ps
`default_nettype none

// Router status and counter registers on APB
// Register file over an ingress and an egress counter bank

module router_stat_regs #(
    parameter int NUM_ING_PORTS = 4,
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic                                               core_clk_ifc,
    input  logic                                               peripheral_sresetn_core,
    input  router_regs_pkg::apb_req_t                          apb_req,
    input  router_regs_pkg::port_traffic_t [NUM_ING_PORTS-1:0] ing_traffic,
    // Bit 0 async FIFO overflow, bit 1 buffer overflow
    input  logic [NUM_ING_PORTS-1:0][1:0]                      ing_events,
    input  router_regs_pkg::port_traffic_t [NUM_EGR_PORTS-1:0] egr_traffic,
    // Buffer-full drop
    input  logic [NUM_EGR_PORTS-1:0]                           egr_events,
    output router_regs_pkg::apb_rsp_t                          apb_rsp,
    output logic [NUM_ING_PORTS-1:0]                           ing_port_enable,
    output logic [NUM_EGR_PORTS-1:0]                           egr_port_enable
);

    import router_regs_pkg::*;

    logic [NUM_ING_PORTS-1:0] ing_sample_req;
    logic [NUM_EGR_PORTS-1:0] egr_sample_req;
    cntr_sel_t                ing_read_sel;
    cntr_sel_t                egr_read_sel;
    logic [CNTR_W-1:0]        ing_read_data;
    logic [CNTR_W-1:0]        egr_read_data;

    apb_register_file #(
        .NUM_ING_PORTS (NUM_ING_PORTS),
        .NUM_EGR_PORTS (NUM_EGR_PORTS)
    ) i_apb_register_file (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .apb_req                 (apb_req),
        .ing_read_data           (ing_read_data),
        .egr_read_data           (egr_read_data),
        .apb_rsp                 (apb_rsp),
        .ing_port_enable         (ing_port_enable),
        .egr_port_enable         (egr_port_enable),
        .ing_sample_req          (ing_sample_req),
        .egr_sample_req          (egr_sample_req),
        .ing_read_sel            (ing_read_sel),
        .egr_read_sel            (egr_read_sel)
    );

    port_counter_bank #(
        .NUM_PORTS  (NUM_ING_PORTS),
        .NUM_EVENTS (2)
    ) ing_bank (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .traffic                 (ing_traffic),
        .events                  (ing_events),
        .sample_req              (ing_sample_req),
        .read_sel                (ing_read_sel),
        .read_data               (ing_read_data)
    );

    port_counter_bank #(
        .NUM_PORTS  (NUM_EGR_PORTS),
        .NUM_EVENTS (1)
    ) egr_bank (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .traffic                 (egr_traffic),
        .events                  (egr_events),
        .sample_req              (egr_sample_req),
        .read_sel                (egr_read_sel),
        .read_data               (egr_read_data)
    );

endmodule

`default_nettype wire

// File: sources.f
logic/router_regs_pkg.sv
logic/port_counter_bank.sv
logic/apb_register_file.sv
logic/router_stat_regs.sv
verification/router_stat_checker.sv
verification/router_stat_regs_tb.sv

// File: verification/router_stat_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Reference model of the router status register map
// Watches APB and the counter inputs, compares responses and enable outputs

module router_stat_checker #(
    parameter int NUM_ING_PORTS = 4,
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic                                               core_clk_ifc,
    input  logic                                               peripheral_sresetn_core,
    input  logic [2:0]                                         test_id,
    input  router_regs_pkg::apb_req_t                          apb_req,
    input  router_regs_pkg::apb_rsp_t                          apb_rsp,
    input  router_regs_pkg::port_traffic_t [NUM_ING_PORTS-1:0] ing_traffic,
    input  logic [NUM_ING_PORTS-1:0][1:0]                      ing_events,
    input  router_regs_pkg::port_traffic_t [NUM_EGR_PORTS-1:0] egr_traffic,
    input  logic [NUM_EGR_PORTS-1:0]                           egr_events,
    input  logic [NUM_ING_PORTS-1:0]                           ing_port_enable,
    input  logic [NUM_EGR_PORTS-1:0]                           egr_port_enable,
    output int                                                 error_count,
    output int                                                 check_count
);

    import router_regs_pkg::*;

    localparam int MAX_PORTS = (NUM_ING_PORTS > NUM_EGR_PORTS) ? NUM_ING_PORTS : NUM_EGR_PORTS;
    localparam int MAX_WORDS = NUM_TRAFFIC_CNTRS + 2;

    // Index 0 is ingress, index 1 egress
    logic [31:0] con_en    [2];
    logic [31:0] stat_en   [2];
    logic [31:0] samp      [2];
    logic [31:0] samp_prev [2];
    logic [15:0] sel       [2];
    logic [31:0] rd_data   [2];
    logic [31:0] snap      [2][MAX_PORTS][MAX_WORDS];
    logic [31:0] ev_cnt    [2][MAX_PORTS][2];
    logic [1:0]  ev_prev   [2][MAX_PORTS];
    logic        write_now;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset_values";
            3'd2:    return "random_access";
            3'd3:    return "ingress_samples";
            3'd4:    return "ingress_events";
            3'd5:    return "egress_bank";
            3'd6:    return "read_sel_out_of_range";
            default: return "startup";
        endcase
    endfunction

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: %s expected %h actual %h", test_name(test_id), what,
                     expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Register map rules

    function automatic int num_ports(input int d);
        return (d == 0) ? NUM_ING_PORTS : NUM_EGR_PORTS;
    endfunction

    function automatic int num_events(input int d);
        return (d == 0) ? 2 : 1;
    endfunction

    function automatic logic [31:0] port_mask(input int d);
        return (32'd1 << num_ports(d)) - 32'd1;
    endfunction

    function automatic logic event_bit(input int d, input int p, input int e);
        if (d == 0) begin
            return ing_events[p][e];
        end
        return egr_events[p];
    endfunction

    function automatic logic [31:0] traffic_word(input int d, input int p, input int w);
        port_traffic_t t;
        if (d == 0) begin
            t = ing_traffic[p];
        end else begin
            t = egr_traffic[p];
        end
        case (w)
            PKT_CNT:  return t.pkt_cnt;
            BYTE_CNT: return t.byte_cnt;
            default:  return t.err_cnt;
        endcase
    endfunction

    function automatic logic [31:0] select_word(input int d);
        int port;
        int idx;
        port = int'(sel[d][15:8]);
        idx  = int'(sel[d][7:0]);
        if (port < num_ports(d) && idx < NUM_TRAFFIC_CNTRS + num_events(d)) begin
            return snap[d][port][idx];
        end
        return 32'h0;
    endfunction

    // Unmapped word, or a write to anything but CON, SAMPLE_CON and READ_SEL
    function automatic logic bus_error();
        int word;
        logic writable;
        word     = int'(apb_req.paddr[ADDR_W-1:2]);
        writable = (word == ING_PORT_ENABLE_CON)  || (word == EGR_PORT_ENABLE_CON) ||
                   (word == ING_CNTRS_SAMPLE_CON) || (word == ING_CNTRS_READ_SEL)  ||
                   (word == EGR_CNTRS_SAMPLE_CON) || (word == EGR_CNTRS_READ_SEL);
        return (word >= TOTAL_REGS) || (apb_req.pwrite && !writable);
    endfunction

    function automatic logic [31:0] register_value(input int word);
        case (word)
            VERSION_ID:           return {MODULE_VERSION, MODULE_ID};
            PARAMS:               return {16'h0000, 8'(NUM_EGR_PORTS), 8'(NUM_ING_PORTS)};
            ING_PORT_ENABLE_CON:  return con_en[0];
            EGR_PORT_ENABLE_CON:  return con_en[1];
            ING_PORT_ENABLE_STAT: return stat_en[0];
            EGR_PORT_ENABLE_STAT: return stat_en[1];
            ING_CNTRS_SAMPLE_CON: return samp[0];
            ING_CNTRS_READ_SEL:   return {16'h0000, sel[0]};
            ING_CNTRS_READ_DATA:  return rd_data[0];
            EGR_CNTRS_SAMPLE_CON: return samp[1];
            EGR_CNTRS_READ_SEL:   return {16'h0000, sel[1]};
            EGR_CNTRS_READ_DATA:  return rd_data[1];
            default:              return 32'h0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Model state updates

    task automatic reset_model();
        for (int d = 0; d < 2; d++) begin
            con_en[d]    = port_mask(d);
            stat_en[d]   = port_mask(d);
            samp[d]      = '0;
            samp_prev[d] = '0;
            sel[d]       = '0;
            rd_data[d]   = '0;
            for (int p = 0; p < MAX_PORTS; p++) begin
                ev_prev[d][p] = '0;
                ev_cnt[d][p]  = '{32'h0, 32'h0};
                for (int w = 0; w < MAX_WORDS; w++) begin
                    snap[d][p][w] = '0;
                end
            end
        end
    endtask

    // Everything here reads the state from before the clock edge
    task automatic advance_banks();
        logic rise;
        logic strobe;
        logic edge_seen;
        for (int d = 0; d < 2; d++) begin
            rd_data[d] = select_word(d);
            for (int p = 0; p < num_ports(d); p++) begin
                rise = samp[d][p] && !samp_prev[d][p];
                if (rise) begin
                    for (int w = 0; w < NUM_TRAFFIC_CNTRS; w++) begin
                        snap[d][p][w] = traffic_word(d, p, w);
                    end
                end
                for (int e = 0; e < num_events(d); e++) begin
                    strobe    = event_bit(d, p, e);
                    edge_seen = strobe && !ev_prev[d][p][e];
                    if (rise) begin
                        snap[d][p][NUM_TRAFFIC_CNTRS + e] = ev_cnt[d][p][e];
                        // An edge on the sample cycle opens the new count
                        ev_cnt[d][p][e] = 32'(edge_seen);
                    end else if (edge_seen) begin
                        ev_cnt[d][p][e] = ev_cnt[d][p][e] + 32'd1;
                    end
                    ev_prev[d][p][e] = strobe;
                end
            end
            samp_prev[d] = samp[d];
            stat_en[d]   = con_en[d];
        end
    endtask

    task automatic apply_write();
        logic [31:0] data;
        data = apb_req.pwdata;
        case (int'(apb_req.paddr[ADDR_W-1:2]))
            ING_PORT_ENABLE_CON:  con_en[0] = data & port_mask(0);
            EGR_PORT_ENABLE_CON:  con_en[1] = data & port_mask(1);
            ING_CNTRS_SAMPLE_CON: samp[0]   = data & port_mask(0);
            EGR_CNTRS_SAMPLE_CON: samp[1]   = data & port_mask(1);
            ING_CNTRS_READ_SEL:   sel[0]    = data[15:0];
            EGR_CNTRS_READ_SEL:   sel[1]    = data[15:0];
            default: ;
        endcase
    endtask

    task automatic check_access();
        logic exp_err;
        exp_err = bus_error();
        compare_word("pslverr", 32'(exp_err), 32'(apb_rsp.pslverr));
        compare_word("pready", 32'd1, 32'(apb_rsp.pready));
        if (!apb_req.pwrite) begin
            compare_word("prdata",
                         exp_err ? 32'h0 : register_value(int'(apb_req.paddr[ADDR_W-1:2])),
                         apb_rsp.prdata);
        end
    endtask

    always @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            reset_model();
        end else begin
            write_now = apb_req.psel && apb_req.penable && apb_req.pwrite && !bus_error();
            if (apb_req.psel && apb_req.penable) begin
                check_access();
            end
            compare_word("ing_port_enable", con_en[0], 32'(ing_port_enable));
            compare_word("egr_port_enable", con_en[1], 32'(egr_port_enable));
            advance_banks();
            if (write_now) begin
                apply_write();
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/router_stat_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench of the router status and counter registers
// Seeded random APB transfers, traffic counts and event strobes

module router_stat_regs_tb;

    import router_regs_pkg::*;

    localparam int NUM_ING_PORTS = 4;
    localparam int NUM_EGR_PORTS = 3;
    localparam int NUM_RANDOM    = 200;
    localparam int NUM_ROUNDS    = 8;
    localparam int NUM_OOR       = 20;

    // Reset reads, random accesses, sample rounds of both banks, out of range reads
    localparam int PLANNED_TRANSFERS = 6 + NUM_RANDOM
        + NUM_ROUNDS * (2 + 2 * NUM_ING_PORTS * 5)
        + NUM_ROUNDS * (2 + 2 * NUM_EGR_PORTS * 4)
        + 4 * NUM_OOR;
    localparam int MAX_CYCLES = PLANNED_TRANSFERS * 8 + 200;

    logic                              core_clk_ifc;
    logic                              peripheral_sresetn_core;
    apb_req_t                          apb_req;
    apb_rsp_t                          apb_rsp;
    port_traffic_t [NUM_ING_PORTS-1:0] ing_traffic;
    logic [NUM_ING_PORTS-1:0][1:0]     ing_events;
    port_traffic_t [NUM_EGR_PORTS-1:0] egr_traffic;
    logic [NUM_EGR_PORTS-1:0]          egr_events;
    logic [NUM_ING_PORTS-1:0]          ing_port_enable;
    logic [NUM_EGR_PORTS-1:0]          egr_port_enable;
    logic [2:0]                        test_id;
    logic                              events_on;
    int                                cycle_count = 0;
    int                                error_count;
    int                                check_count;

    router_stat_regs #(
        .NUM_ING_PORTS (NUM_ING_PORTS),
        .NUM_EGR_PORTS (NUM_EGR_PORTS)
    ) i_router_stat_regs (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .apb_req                 (apb_req),
        .ing_traffic             (ing_traffic),
        .ing_events              (ing_events),
        .egr_traffic             (egr_traffic),
        .egr_events              (egr_events),
        .apb_rsp                 (apb_rsp),
        .ing_port_enable         (ing_port_enable),
        .egr_port_enable         (egr_port_enable)
    );

    router_stat_checker #(
        .NUM_ING_PORTS (NUM_ING_PORTS),
        .NUM_EGR_PORTS (NUM_EGR_PORTS)
    ) i_router_stat_checker (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .test_id                 (test_id),
        .apb_req                 (apb_req),
        .apb_rsp                 (apb_rsp),
        .ing_traffic             (ing_traffic),
        .ing_events              (ing_events),
        .egr_traffic             (egr_traffic),
        .egr_events              (egr_events),
        .ing_port_enable         (ing_port_enable),
        .egr_port_enable         (egr_port_enable),
        .error_count             (error_count),
        .check_count             (check_count)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycle_count <= cycle_count + 1;
    end

    // Random toggles give strobe pulses of random length
    always @(posedge core_clk_ifc) begin
        if (events_on) begin
            for (int p = 0; p < NUM_ING_PORTS; p++) begin
                for (int e = 0; e < 2; e++) begin
                    if ($urandom_range(0, 2) == 0) begin
                        ing_events[p][e] <= !ing_events[p][e];
                    end
                end
            end
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if ($urandom_range(0, 2) == 0) begin
                    egr_events[p] <= !egr_events[p];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB master

    // Setup, access, then three idle cycles
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data);
        @(posedge core_clk_ifc);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge core_clk_ifc);
        apb_req.penable <= 1'b1;
        @(posedge core_clk_ifc);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        repeat (2) @(posedge core_clk_ifc);
    endtask

    task automatic write_reg(input reg_addr_e r, input logic [31:0] data);
        apb_transfer(1'b1, {r, 2'b00}, data);
    endtask

    task automatic read_reg(input reg_addr_e r);
        apb_transfer(1'b0, {r, 2'b00}, 32'h0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic randomize_traffic();
        for (int p = 0; p < NUM_ING_PORTS; p++) begin
            ing_traffic[p] <= {$urandom, $urandom, $urandom};
        end
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            egr_traffic[p] <= {$urandom, $urandom, $urandom};
        end
    endtask

    // Random sample mask, then every port's words first_idx to last_idx
    task automatic sample_round(input bit egress, input int first_idx, input int last_idx);
        int nports;
        nports = egress ? NUM_EGR_PORTS : NUM_ING_PORTS;
        write_reg(egress ? EGR_CNTRS_SAMPLE_CON : ING_CNTRS_SAMPLE_CON, $urandom);
        for (int p = 0; p < nports; p++) begin
            for (int idx = first_idx; idx <= last_idx; idx++) begin
                write_reg(egress ? EGR_CNTRS_READ_SEL : ING_CNTRS_READ_SEL,
                          {16'h0000, 8'(p), 8'(idx)});
                read_reg(egress ? EGR_CNTRS_READ_DATA : ING_CNTRS_READ_DATA);
            end
        end
    endtask

    task automatic out_of_range_read(input bit egress);
        int nports;
        int nwords;
        int port;
        int idx;
        nports = egress ? NUM_EGR_PORTS : NUM_ING_PORTS;
        nwords = egress ? 4 : 5;
        port   = $urandom_range(0, 255);
        idx    = $urandom_range(0, 255);
        if ($urandom_range(0, 1) == 1) begin
            port = $urandom_range(nports, 255);
        end else begin
            idx = $urandom_range(nwords, 255);
        end
        write_reg(egress ? EGR_CNTRS_READ_SEL : ING_CNTRS_READ_SEL,
                  {16'h0000, 8'(port), 8'(idx)});
        read_reg(egress ? EGR_CNTRS_READ_DATA : ING_CNTRS_READ_DATA);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int word;
        logic [7:0] addr;

        void'($urandom(32'h6301_f6ce));
        peripheral_sresetn_core = 1'b0;
        apb_req                 = '0;
        ing_traffic             = '0;
        ing_events              = '0;
        egr_traffic             = '0;
        egr_events              = '0;
        events_on               = 1'b0;
        test_id                 = 3'd0;
        repeat (2) @(posedge core_clk_ifc);
        peripheral_sresetn_core <= 1'b1;

        test_id <= 3'd1;
        read_reg(VERSION_ID);
        read_reg(PARAMS);
        read_reg(ING_PORT_ENABLE_CON);
        read_reg(EGR_PORT_ENABLE_CON);
        read_reg(ING_PORT_ENABLE_STAT);
        read_reg(EGR_PORT_ENABLE_STAT);

        // Mostly mapped words, some beyond the register map
        test_id <= 3'd2;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if ($urandom_range(0, 7) == 0) begin
                word = $urandom_range(12, 63);
            end else begin
                word = $urandom_range(0, 11);
            end
            addr = {word[5:0], 2'($urandom_range(0, 3))};
            apb_transfer(1'($urandom_range(0, 1)), addr, $urandom);
        end

        test_id <= 3'd3;
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            randomize_traffic();
            sample_round(1'b0, 0, 2);
        end

        test_id   <= 3'd4;
        events_on <= 1'b1;
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            sample_round(1'b0, 3, 4);
        end

        test_id <= 3'd5;
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            randomize_traffic();
            sample_round(1'b1, 0, 2);
        end
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            sample_round(1'b1, 3, 3);
        end

        test_id <= 3'd6;
        for (int i = 0; i < NUM_OOR; i++) begin
            out_of_range_read(1'b0);
            out_of_range_read(1'b1);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
